/* flist.f */
dbg_or1k_pkg.sv
dbg_or1k_crc32.sv
dbg_or1k_status_reg.sv
dbg_or1k_biu.sv
dbg_or1k_datapath.sv
dbg_or1k_fsm.sv
dbg_or1k_module.sv
tb_dbg_or1k.sv

/* tb_dbg_or1k.sv */
// Testbench for the OR1K debug module
// TAP and SPR bus models drive bursts, status access and an abort;
// concurrent assertions compare the DUT against the models
`default_nettype none

module tb_dbg_or1k import dbg_or1k_pkg::*; ;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WR_WORDS    = 3;
  localparam int RD_WORDS    = 4;
  localparam int ABORT_BITS  = 1 + WORD_WIDTH + 8;   // Start bit, one word, part of next
  localparam int READY_POLLS = 16;
  localparam int TOTAL_BITS  = 9 * DR_WIDTH + 4 + 2 * (2 + 32 * WR_WORDS + 32) +
                               (1 + 32 * RD_WORDS + 32) + ABORT_BITS;
  localparam int WATCHDOG_NS = 20 * TOTAL_BITS * 8;

  typedef struct packed {
    logic      we;
    dbg_addr_t addr;
    dbg_word_t data;
  } xfer_t;

  logic                tck;
  logic                rst;
  logic                tdi;
  logic                capture_dr;
  logic                shift_dr;
  logic                update_dr;
  logic                module_select;
  logic [DR_WIDTH-1:0] dr;              // TAP data register model
  logic                module_tdo;
  logic                top_inhibit;
  spr_req_t            spr_req;
  dbg_word_t           cpu_data;
  logic                cpu_ack;
  logic                cpu_bp;
  logic                cpu_stall;
  logic                cpu_rst;

  logic [31:0] lfsr = 32'h3d0f;
  xfer_t       exp_q[$];                // SPR transfers still to come
  xfer_t       exp_xfer;                // Transfer being acked
  logic        xfer_ok;
  logic        chk_reset, chk_status, chk_tdo, chk_inhibit, chk_idle;
  logic        exp_stall, exp_rst, exp_tdo;
  string       tdo_what;
  int          err_reset, err_status, err_bus, err_tdo, err_inhibit, err_idle, err_other;

  dbg_or1k_module i_dbg_or1k_module (
    .tck_i           (tck),
    .rst_i           (rst),
    .tdi_i           (tdi),
    .capture_dr_i    (capture_dr),
    .shift_dr_i      (shift_dr),
    .update_dr_i     (update_dr),
    .module_select_i (module_select),
    .data_register_i (dr),
    .module_tdo_o    (module_tdo),
    .top_inhibit_o   (top_inhibit),
    .spr_req_o       (spr_req),
    .cpu_data_i      (cpu_data),
    .cpu_ack_i       (cpu_ack),
    .cpu_bp_i        (cpu_bp),
    .cpu_stall_o     (cpu_stall),
    .cpu_rst_o       (cpu_rst)
  );

  initial begin
    tck = 1'b0;
    forever #4 tck = ~tck;
  end

  //////////////////////////////
  // Helpers

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // Reflected CRC-32, one bit
  function automatic dbg_word_t crc_next(input dbg_word_t crc, input logic b);
    dbg_word_t r;
    r = crc >> 1;
    if (crc[0] ^ b) r = r ^ 32'hedb8_8320;
    return r;
  endfunction

  // SPR memory contents, mixes every address bit
  function automatic dbg_word_t mem_word(input dbg_addr_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a0f_c3e1;
  endfunction

  function automatic logic [DR_WIDTH-1:0] make_cmd(input dbg_op_t op, input dbg_addr_t addr,
                                                   input dbg_count_t count);
    return {1'b0, op, addr, count};  // Flag low marks a module command
  endfunction

  task automatic print_check_failure(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  // One TCK cycle, inputs change on the falling edge
  task automatic tap_cycle(input logic cap, input logic sh, input logic upd, input logic b);
    @(negedge tck);
    if (shift_dr) dr = {tdi, dr[DR_WIDTH-1:1]};  // Bit taken at the last rising edge
    if (cap) dr = '0;
    capture_dr = cap;
    shift_dr   = sh;
    update_dr  = upd;
    tdi        = b;
    chk_tdo    = 1'b0;
  endtask

  task automatic send_cmd(input logic [DR_WIDTH-1:0] cmd);
    int i;
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    for (i = 0; i < DR_WIDTH; i++) tap_cycle(1'b0, 1'b1, 1'b0, cmd[i]);  // LSB first
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // Capture and shift out the two status bits, stall first
  task automatic read_status_bits();
    tdo_what = "status bit";
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
    chk_tdo = 1'b1;
    exp_tdo = exp_stall;                                   // Bit 0 first
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
    chk_tdo = 1'b1;
    exp_tdo = exp_rst;
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  //////////////////////////////
  // Tests

  task automatic status_test();
    send_cmd(make_cmd(CMD_IREG_SEL, {INTREG_STATUS, 31'b0}, '0));
    send_cmd(make_cmd(CMD_IREG_WR, {INTREG_STATUS, 2'b01, 29'b0}, '0));
    exp_stall  = 1'b1;                                     // Stall set, reset clear
    exp_rst    = 1'b0;
    chk_status = 1'b1;
    read_status_bits();
    chk_status = 1'b0;
    send_cmd(make_cmd(CMD_IREG_WR, {INTREG_STATUS, 2'b00, 29'b0}, '0));
    exp_stall  = 1'b0;
    chk_status = 1'b1;
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    cpu_bp = 1'b1;                                         // Breakpoint for one cycle
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    cpu_bp    = 1'b0;
    exp_stall = 1'b1;
    repeat (2) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    chk_status = 1'b0;
    // CPU reset bit on its own
    send_cmd(make_cmd(CMD_IREG_WR, {INTREG_STATUS, 2'b10, 29'b0}, '0));
    exp_stall  = 1'b0;
    exp_rst    = 1'b1;
    chk_status = 1'b1;
    read_status_bits();
    chk_status = 1'b0;
    send_cmd(make_cmd(CMD_IREG_WR, {INTREG_STATUS, 2'b00, 29'b0}, '0));
    exp_rst    = 1'b0;
    chk_status = 1'b1;
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    chk_status = 1'b0;
  endtask

  // Burst write of n random words, optionally with one CRC bit flipped
  task automatic write_burst(input dbg_addr_t addr, input int n, input logic bad_crc);
    dbg_word_t words[$];
    dbg_word_t crc;
    dbg_word_t crc_sent;
    int        i;
    int        b;
    crc = '1;
    for (i = 0; i < n; i++) begin
      words.push_back(rand_bits(WORD_WIDTH));
      exp_q.push_back('{we: 1'b1, addr: addr + i, data: words[i]});
    end
    send_cmd(make_cmd(CMD_BWRITE32, addr, dbg_count_t'(n)));
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b1);                     // Start bit
    chk_inhibit = 1'b1;
    for (i = 0; i < n; i++) begin
      for (b = 0; b < WORD_WIDTH; b++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, words[i][b]);
        crc = crc_next(crc, words[i][b]);
      end
    end
    crc_sent = bad_crc ? crc ^ (32'h1 << 5) : crc;
    for (b = 0; b < WORD_WIDTH; b++) tap_cycle(1'b0, 1'b1, 1'b0, crc_sent[b]);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);                     // Match bit comes out here
    chk_tdo  = 1'b1;
    exp_tdo  = (crc_sent == crc);
    tdo_what = "CRC match bit";
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    chk_inhibit = 1'b0;
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic read_burst(input dbg_addr_t addr, input int n);
    dbg_word_t crc;
    dbg_word_t w;
    logic      seen;
    int        polls;
    int        i;
    int        b;
    crc = '1;
    for (i = 0; i < n; i++) exp_q.push_back('{we: 1'b0, addr: addr + i, data: '0});
    send_cmd(make_cmd(CMD_BREAD32, addr, dbg_count_t'(n)));
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    seen  = 1'b0;
    polls = 0;
    while (!seen && polls < READY_POLLS) begin             // Wait for the ready bit
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
      chk_inhibit = 1'b1;
      #1 seen = module_tdo;
      polls++;
    end
    if (!seen) begin
      err_other++;
      $display("Read burst at %h: ready bit never came after %0d polls", addr, polls);
    end else begin
      tdo_what = "read data bit";
      for (i = 0; i < n; i++) begin
        w = mem_word(addr + i);
        for (b = 0; b < WORD_WIDTH; b++) begin
          tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
          chk_tdo = 1'b1;
          exp_tdo = w[b];
          crc     = crc_next(crc, w[b]);
        end
      end
      tdo_what = "read CRC bit";
      for (b = 0; b < WORD_WIDTH; b++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, 1'b0);
        chk_tdo = 1'b1;
        exp_tdo = crc[b];
      end
    end
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    chk_inhibit = 1'b0;
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // Update in the middle of word 1 of a four word write
  task automatic abort_write(input dbg_addr_t addr);
    dbg_word_t w0;
    dbg_word_t w1;
    int        b;
    w0 = rand_bits(WORD_WIDTH);
    w1 = rand_bits(WORD_WIDTH);
    exp_q.push_back('{we: 1'b1, addr: addr, data: w0});   // Only word 0 reaches the bus
    send_cmd(make_cmd(CMD_BWRITE32, addr, 16'd4));
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b1);
    chk_inhibit = 1'b1;
    for (b = 0; b < WORD_WIDTH; b++) tap_cycle(1'b0, 1'b1, 1'b0, w0[b]);
    for (b = 0; b < 8; b++) tap_cycle(1'b0, 1'b1, 1'b0, w1[b]);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    chk_inhibit = 1'b0;
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    chk_idle = 1'b1;                                       // Back in IDLE from here
    repeat (48) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    chk_idle = 1'b0;
  endtask

  //////////////////////////////
  // SPR bus model, acks after 1 to 8 cycles
  initial begin : spr_memory
    int   wait_left;
    logic pending;
    pending   = 1'b0;
    wait_left = 0;
    forever begin
      @(negedge tck);
      if (cpu_ack) begin
        cpu_ack = 1'b0;                  // Single cycle ack
      end else if (spr_req.stb === 1'b1) begin
        if (!pending) begin
          pending   = 1'b1;
          wait_left = 1 + int'(rand_bits(3));
        end
        wait_left--;
        if (wait_left == 0) begin
          pending  = 1'b0;
          cpu_ack  = 1'b1;
          cpu_data = mem_word(spr_req.addr);
          xfer_ok  = (exp_q.size() != 0);
          if (xfer_ok) exp_xfer = exp_q.pop_front();
        end
      end
    end
  end

  //////////////////////////////
  // Checks
  a_reset: assert property (@(posedge tck)
    chk_reset |-> !spr_req.stb && !top_inhibit && !cpu_stall && !cpu_rst)
    else begin
      err_reset++;
      print_check_failure("output not low after reset");
    end

  a_status: assert property (@(posedge tck) disable iff (rst)
    chk_status |-> cpu_stall == exp_stall && cpu_rst == exp_rst)
    else begin
      err_status++;
      print_check_failure($sformatf("stall/reset %b%b, expected %b%b", $sampled(cpu_stall),
                          $sampled(cpu_rst), $sampled(exp_stall), $sampled(exp_rst)));
    end

  a_tdo: assert property (@(posedge tck) disable iff (rst)
    chk_tdo |-> module_tdo == exp_tdo)
    else begin
      err_tdo++;
      print_check_failure($sformatf("%s on TDO is %b, expected %b", tdo_what,
                          $sampled(module_tdo), $sampled(exp_tdo)));
    end

  a_bus_expected: assert property (@(posedge tck) disable iff (rst)
    spr_req.stb && cpu_ack |-> xfer_ok)
    else begin
      err_bus++;
      print_check_failure("SPR transfer that no test expected");
    end

  a_bus_match: assert property (@(posedge tck) disable iff (rst)
    spr_req.stb && cpu_ack && xfer_ok |-> spr_req.we == exp_xfer.we &&
      spr_req.addr == exp_xfer.addr && (!exp_xfer.we || spr_req.data == exp_xfer.data))
    else begin
      err_bus++;
      print_check_failure($sformatf("SPR we/addr/data %b %h %h, expected %b %h %h",
                          $sampled(spr_req.we), $sampled(spr_req.addr), $sampled(spr_req.data),
                          $sampled(exp_xfer.we), $sampled(exp_xfer.addr),
                          $sampled(exp_xfer.data)));
    end

  a_inhibit: assert property (@(posedge tck) disable iff (rst)
    chk_inhibit |-> top_inhibit)
    else begin
      err_inhibit++;
      print_check_failure("top_inhibit low during burst shift");
    end

  a_idle: assert property (@(posedge tck) disable iff (rst)
    chk_idle |-> !top_inhibit && !$rose(spr_req.stb))
    else begin
      err_idle++;
      print_check_failure("module still busy after aborting update");
    end

  //////////////////////////////
  // Main sequence
  initial begin : main
    int total;
    rst           = 1'b1;
    tdi           = 1'b0;
    capture_dr    = 1'b0;
    shift_dr      = 1'b0;
    update_dr     = 1'b0;
    module_select = 1'b0;
    dr            = '0;
    cpu_data      = '0;
    cpu_ack       = 1'b0;
    cpu_bp        = 1'b0;
    exp_xfer      = '0;
    xfer_ok       = 1'b0;
    {chk_reset, chk_status, chk_tdo, chk_inhibit, chk_idle} = '0;
    {exp_stall, exp_rst, exp_tdo} = '0;
    tdo_what = "";
    {err_reset, err_status, err_bus, err_tdo, err_inhibit, err_idle, err_other} = '0;

    @(negedge tck);
    chk_reset = 1'b1;
    repeat (3) @(negedge tck);
    rst = 1'b0;                          // Held for four rising edges
    repeat (3) @(negedge tck);
    chk_reset     = 1'b0;
    module_select = 1'b1;

    status_test();
    write_burst(32'h0000_2800, WR_WORDS, 1'b0);
    write_burst(32'h0000_3000, WR_WORDS, 1'b1);
    read_burst(32'h0000_1c00, RD_WORDS);
    abort_write(32'h0000_4000);
    repeat (20) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);

    if (exp_q.size() != 0) begin
      err_other++;
      $display("%0d expected SPR transfers never reached the bus", exp_q.size());
    end
    total = err_reset + err_status + err_bus + err_tdo + err_inhibit + err_idle + err_other;
    $display("Errors: reset %0d, status %0d, bus %0d, tdo %0d, inhibit %0d, idle %0d, other %0d",
             err_reset, err_status, err_bus, err_tdo, err_inhibit, err_idle, err_other);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog scaled to the number of shifted bits
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dbg_or1k_module.sv */
// OR1K CPU debug module, top level
// Connects the control FSM, datapath, SPR bus unit and status register
`default_nettype none

module dbg_or1k_module import dbg_or1k_pkg::*; (
  input  wire logic                tck_i,
  input  wire logic                rst_i,
  input  wire logic                tdi_i,
  input  wire logic                capture_dr_i,
  input  wire logic                shift_dr_i,
  input  wire logic                update_dr_i,
  input  wire logic                module_select_i,
  input  wire logic [DR_WIDTH-1:0] data_register_i,
  output logic                     module_tdo_o,
  output logic                     top_inhibit_o,
  output spr_req_t                 spr_req_o,
  input  wire dbg_word_t           cpu_data_i,
  input  wire logic                cpu_ack_i,
  input  wire logic                cpu_bp_i,
  output logic                     cpu_stall_o,
  output logic                     cpu_rst_o
);

  dbg_ctrl_t  ctrl;
  dbg_stat_t  stat;
  dbg_word_t  biu_rdata;
  dbg_addr_t  biu_addr;
  logic       biu_rdy;
  logic       biu_strobe;
  logic       rd_op;
  logic       status_we;
  logic [1:0] status;

  //////////////////////////////
  // Control path
  dbg_or1k_fsm i_fsm (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .module_select_i (module_select_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .data_register_i (data_register_i),
    .stat_i          (stat),
    .biu_rdy_i       (biu_rdy),
    .ctrl_o          (ctrl),
    .biu_strobe_o    (biu_strobe),
    .status_we_o     (status_we),
    .top_inhibit_o   (top_inhibit_o)
  );

  dbg_or1k_datapath i_datapath (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .data_register_i (data_register_i),
    .ctrl_i          (ctrl),
    .stat_o          (stat),
    .biu_data_i      (biu_rdata),
    .biu_rdy_i       (biu_rdy),
    .addr_o          (biu_addr),
    .rd_op_o         (rd_op),
    .status_i        (status),
    .module_tdo_o    (module_tdo_o)
  );

  // Write word is TDI plus the top of the data register, one bit ahead
  dbg_or1k_biu i_biu (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .strobe_i   (biu_strobe),
    .rd_wrn_i   (rd_op),
    .addr_i     (biu_addr),
    .data_i     ({tdi_i, data_register_i[CMD_FLAG_BIT -: WORD_WIDTH-1]}),
    .data_o     (biu_rdata),
    .rdy_o      (biu_rdy),
    .spr_req_o  (spr_req_o),
    .cpu_data_i (cpu_data_i),
    .cpu_ack_i  (cpu_ack_i)
  );

  dbg_or1k_status_reg i_status_reg (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .we_i        (status_we),
    .data_i      (data_register_i[STWR_MSB:STWR_LSB]),
    .bp_i        (cpu_bp_i),
    .ctrl_o      (status),
    .cpu_stall_o (cpu_stall_o),
    .cpu_rst_o   (cpu_rst_o)
  );

endmodule

`default_nettype wire

/* dbg_or1k_fsm.sv */
// Control FSM of the OR1K debug module
// Decodes module commands and sequences high-speed read and write bursts,
// internal register select/write and capture
`default_nettype none

module dbg_or1k_fsm import dbg_or1k_pkg::*; (
  input  wire logic                tck_i,
  input  wire logic                rst_i,
  input  wire logic                module_select_i,
  input  wire logic                capture_dr_i,
  input  wire logic                shift_dr_i,
  input  wire logic                update_dr_i,
  input  wire logic [DR_WIDTH-1:0] data_register_i,
  input  wire dbg_stat_t           stat_i,
  input  wire logic                biu_rdy_i,
  output dbg_ctrl_t                ctrl_o,
  output logic                     biu_strobe_o,
  output logic                     status_we_o,
  output logic                     top_inhibit_o
);

  dbg_state_e state_q;
  dbg_state_e state_d;
  dbg_op_t    op_in;
  logic       module_cmd;  // Command flag low
  logic       upd_cmd;     // Module command on update
  logic       burst_cmd;
  logic       intreg_cmd;
  logic       load_word;   // Read burst takes the next BIU word

  assign op_in      = data_register_i[OP_MSB:OP_LSB];
  assign module_cmd = ~data_register_i[CMD_FLAG_BIT];
  assign upd_cmd    = module_select_i & update_dr_i & module_cmd;
  assign burst_cmd  = (op_in == CMD_BWRITE32) || (op_in == CMD_BREAD32);
  assign intreg_cmd = (op_in == CMD_IREG_WR) || (op_in == CMD_IREG_SEL);

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Next state and datapath enables
  always_comb begin
    state_d        = state_q;
    ctrl_o         = '0;
    ctrl_o.tdo_sel = TDO_DATA;
    biu_strobe_o   = 1'b0;
    status_we_o    = 1'b0;
    top_inhibit_o  = 1'b0;
    load_word      = 1'b0;

    case (state_q)
      IDLE: begin
        ctrl_o.out_shift  = module_select_i & shift_dr_i;    // Internal reg readout
        ctrl_o.out_ld     = module_select_i & capture_dr_i;
        ctrl_o.out_intreg = 1'b1;
        ctrl_o.regsel_ld  = upd_cmd & intreg_cmd;
        status_we_o       = upd_cmd && (op_in == CMD_IREG_WR) &&
                            (data_register_i[REGSEL_BIT -: REGSEL_WIDTH] == INTREG_STATUS);
        if (upd_cmd && burst_cmd) begin
          state_d        = (op_in == CMD_BREAD32) ? RBEGIN : WREADY;
          ctrl_o.addr_ld = 1'b1;
          ctrl_o.op_ld   = 1'b1;
          ctrl_o.bit_clr = 1'b1;
          ctrl_o.word_ld = 1'b1;
          ctrl_o.crc_clr = 1'b1;
        end
      end
      RBEGIN: begin
        if (stat_i.word_zero) begin
          state_d = IDLE;  // Empty burst
        end else begin
          state_d         = RREADY;
          biu_strobe_o    = 1'b1;  // First read
          ctrl_o.addr_inc = 1'b1;
        end
      end
      RREADY: begin
        if (update_dr_i) state_d = IDLE;
        else if (module_select_i && capture_dr_i) state_d = RSTATUS;
      end
      RSTATUS: begin
        ctrl_o.tdo_sel = TDO_READY;
        top_inhibit_o  = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (biu_rdy_i) begin
          state_d   = RBURST;
          load_word = 1'b1;
        end
      end
      RBURST: begin
        ctrl_o.out_shift = 1'b1;
        ctrl_o.bit_step  = 1'b1;
        ctrl_o.crc_en    = 1'b1;  // CRC over TDO data
        top_inhibit_o    = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (stat_i.bit_max) begin
          if (stat_i.word_zero) state_d = RCRC;
          else load_word = 1'b1;  // No gap between words
        end
      end
      RCRC: begin
        ctrl_o.tdo_sel   = TDO_CRC;
        ctrl_o.crc_shift = 1'b1;
        top_inhibit_o    = 1'b1;
        if (update_dr_i) state_d = IDLE;
      end
      WREADY: begin
        if (stat_i.word_zero || update_dr_i) state_d = IDLE;
        else if (module_select_i && capture_dr_i) state_d = WWAIT;
      end
      WWAIT: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (module_select_i && data_register_i[CMD_FLAG_BIT]) begin
          state_d         = WBURST;  // Start bit seen, TDI holds bit 0
          ctrl_o.bit_step = 1'b1;
          ctrl_o.word_dec = 1'b1;
          ctrl_o.crc_en   = 1'b1;
          ctrl_o.crc_tdi  = 1'b1;
        end
      end
      WBURST: begin
        ctrl_o.bit_step = 1'b1;
        ctrl_o.crc_en   = 1'b1;
        ctrl_o.crc_tdi  = 1'b1;
        top_inhibit_o   = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (stat_i.bit_max) begin
          ctrl_o.bit_clr  = 1'b1;
          ctrl_o.addr_inc = 1'b1;
          biu_strobe_o    = 1'b1;  // Word complete with TDI as bit 31
          if (stat_i.word_zero) state_d = WCRC;
          else ctrl_o.word_dec = 1'b1;
        end
      end
      WCRC: begin
        ctrl_o.bit_step = 1'b1;
        top_inhibit_o   = 1'b1;
        if (update_dr_i) begin
          state_d = IDLE;
        end else if (stat_i.bit_32) begin
          state_d        = WMATCH;
          ctrl_o.tdo_sel = TDO_MATCH;  // Host reads the match bit now
        end
      end
      WMATCH: begin
        ctrl_o.tdo_sel = TDO_MATCH;
        top_inhibit_o  = 1'b1;
        if (update_dr_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase

    // Load the next read word and strobe the one after it
    if (load_word) begin
      ctrl_o.out_ld   = 1'b1;
      ctrl_o.bit_clr  = 1'b1;
      ctrl_o.word_dec = 1'b1;
      if (!stat_i.word_last) begin
        biu_strobe_o    = 1'b1;
        ctrl_o.addr_inc = 1'b1;
      end
    end
  end

  a_state_legal: assert property (@(posedge tck_i) disable iff (rst_i)
    state_q inside {IDLE, RBEGIN, RREADY, RSTATUS, RBURST, RCRC,
                    WREADY, WWAIT, WBURST, WCRC, WMATCH});

endmodule

`default_nettype wire

/* dbg_or1k_datapath.sv */
// Datapath of the OR1K debug module
// Address, word and bit counters, opcode latch, register select,
// output shift register, CRC and the TDO mux
`default_nettype none

module dbg_or1k_datapath import dbg_or1k_pkg::*; (
  input  wire logic                tck_i,
  input  wire logic                rst_i,
  input  wire logic                tdi_i,
  input  wire logic [DR_WIDTH-1:0] data_register_i,
  input  wire dbg_ctrl_t           ctrl_i,
  output dbg_stat_t                stat_o,
  input  wire dbg_word_t           biu_data_i,
  input  wire logic                biu_rdy_i,
  output dbg_addr_t                addr_o,
  output logic                     rd_op_o,
  input  wire logic [1:0]          status_i,
  output logic                     module_tdo_o
);

  dbg_addr_t                   addr_q;       // Next SPR address
  dbg_count_t                  word_q;       // Words left in the burst
  logic [BIT_COUNT_WIDTH-1:0]  bit_q;
  dbg_op_t                     op_q;
  logic [REGSEL_WIDTH-1:0]     regsel_q;
  dbg_word_t                   out_q;        // Parallel-load output shift register
  dbg_word_t                   intreg_data;
  dbg_word_t                   crc;
  logic                        crc_serial;
  logic                        crc_match;

  //////////////////////////////
  // Counters and latches
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q   <= '0;
      word_q   <= '0;
      bit_q    <= '0;
      op_q     <= '0;
      regsel_q <= '0;
    end else begin
      if (ctrl_i.addr_ld) begin
        addr_q <= data_register_i[ADDR_MSB:ADDR_LSB];
      end else if (ctrl_i.addr_inc) begin
        addr_q <= addr_q + 1'b1;  // SPRs are word addressed
      end
      if (ctrl_i.word_ld) begin
        word_q <= data_register_i[COUNT_MSB:COUNT_LSB];
      end else if (ctrl_i.word_dec) begin
        word_q <= word_q - 1'b1;
      end
      if (ctrl_i.bit_clr) begin
        bit_q <= '0;
      end else if (ctrl_i.bit_step) begin
        bit_q <= bit_q + 1'b1;
      end
      if (ctrl_i.op_ld) op_q <= data_register_i[OP_MSB:OP_LSB];
      if (ctrl_i.regsel_ld) regsel_q <= data_register_i[REGSEL_BIT -: REGSEL_WIDTH];
    end
  end

  assign stat_o = '{
    word_zero: (word_q == '0),
    word_last: (word_q == COUNT_WIDTH'(1)),
    bit_max:   (bit_q == BIT_COUNT_WIDTH'(WORD_WIDTH - 1)),
    bit_32:    (bit_q == BIT_COUNT_WIDTH'(WORD_WIDTH))
  };

  assign addr_o  = addr_q;
  assign rd_op_o = (op_q == CMD_BREAD32);  // Else a write burst

  // Internal register read mux
  always_comb begin
    case (regsel_q)
      INTREG_STATUS: intreg_data = {{(WORD_WIDTH-2){1'b0}}, status_i};
      default:       intreg_data = '0;
    endcase
  end

  // Output shift register, LSB goes out first
  always_ff @(posedge tck_i) begin
    if (ctrl_i.out_ld) begin
      out_q <= ctrl_i.out_intreg ? intreg_data : biu_data_i;
    end else if (ctrl_i.out_shift) begin
      out_q <= {1'b0, out_q[WORD_WIDTH-1:1]};
    end
  end

  //////////////////////////////
  // CRC over write data from TDI or read data on TDO
  dbg_or1k_crc32 i_crc32 (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .clr_i    (ctrl_i.crc_clr),
    .en_i     (ctrl_i.crc_en),
    .shift_i  (ctrl_i.crc_shift),
    .data_i   (ctrl_i.crc_tdi ? tdi_i : out_q[0]),
    .crc_o    (crc),
    .serial_o (crc_serial)
  );

  // Host CRC sits in the top 32 bits of the data register
  assign crc_match = (data_register_i[CMD_FLAG_BIT -: WORD_WIDTH] == crc);

  always_comb begin
    case (ctrl_i.tdo_sel)
      TDO_READY: module_tdo_o = biu_rdy_i;
      TDO_DATA:  module_tdo_o = out_q[0];
      TDO_MATCH: module_tdo_o = crc_match;
      default:   module_tdo_o = crc_serial;
    endcase
  end

endmodule

`default_nettype wire

/* dbg_or1k_biu.sv */
// SPR bus interface unit
// Latches one transfer on strobe and runs the stb/ack handshake,
// holding read data until the next transfer
`default_nettype none

module dbg_or1k_biu import dbg_or1k_pkg::*; (
  input  wire logic      tck_i,
  input  wire logic      rst_i,
  input  wire logic      strobe_i,   // Start a transfer
  input  wire logic      rd_wrn_i,   // 1 = read
  input  wire dbg_addr_t addr_i,
  input  wire dbg_word_t data_i,
  output dbg_word_t      data_o,
  output logic           rdy_o,
  output spr_req_t       spr_req_o,
  input  wire dbg_word_t cpu_data_i,
  input  wire logic      cpu_ack_i
);

  logic      stb_q;
  logic      we_q;
  dbg_addr_t addr_q;
  dbg_word_t wdata_q;
  dbg_word_t rdata_q;

  //////////////////////////////
  // Handshake control
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stb_q <= 1'b0;
      we_q  <= 1'b0;
    end else if (strobe_i) begin
      stb_q <= 1'b1;
      we_q  <= ~rd_wrn_i;
    end else if (stb_q && cpu_ack_i) begin
      stb_q <= 1'b0;  // Drop in the cycle after ack
      we_q  <= 1'b0;
    end
  end

  // Transfer payload
  always_ff @(posedge tck_i) begin
    if (strobe_i) begin
      addr_q  <= addr_i;
      wdata_q <= data_i;
    end
    if (stb_q && cpu_ack_i && !we_q) begin
      rdata_q <= cpu_data_i;  // Captured in the ack cycle
    end
  end

  assign rdy_o     = ~stb_q;
  assign data_o    = rdata_q;
  assign spr_req_o = '{addr: addr_q, data: wdata_q, stb: stb_q, we: we_q};

  //////////////////////////////
  // Checks

  // A strobe from the FSM must find the previous transfer acked
  a_no_strobe_busy: assert property (@(posedge tck_i) disable iff (rst_i)
    strobe_i |-> rdy_o);

  // Request held steady until the CPU acks
  a_req_stable: assert property (@(posedge tck_i) disable iff (rst_i)
    stb_q && !cpu_ack_i |=> stb_q && $stable(addr_q) && $stable(wdata_q) && $stable(we_q));

endmodule

`default_nettype wire

/* dbg_or1k_status_reg.sv */
// CPU control register of the debug module
// Bit 0 stalls the CPU, bit 1 resets it; a breakpoint sets the stall bit
`default_nettype none

module dbg_or1k_status_reg (
  input  wire logic       tck_i,
  input  wire logic       rst_i,
  input  wire logic       we_i,
  input  wire logic [1:0] data_i,
  input  wire logic       bp_i,       // Breakpoint hit
  output logic      [1:0] ctrl_o,
  output logic            cpu_stall_o,
  output logic            cpu_rst_o
);

  logic [1:0] ctrl_q;
  logic [1:0] ctrl_d;

  always_comb begin
    ctrl_d = we_i ? data_i : ctrl_q;
    if (bp_i) begin
      ctrl_d[0] = 1'b1;  // Breakpoint wins over a write
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_d;
    end
  end

  assign ctrl_o      = ctrl_q;
  assign cpu_stall_o = ctrl_q[0];
  assign cpu_rst_o   = ctrl_q[1];

endmodule

`default_nettype wire

/* dbg_or1k_crc32.sv */
// Bit-serial reflected CRC-32 for debug bursts
// The CRC register also serves as its own output shift register
`default_nettype none

module dbg_or1k_crc32 import dbg_or1k_pkg::*; (
  input  wire logic      tck_i,
  input  wire logic      rst_i,
  input  wire logic      clr_i,     // Back to all ones
  input  wire logic      en_i,      // One data bit per cycle
  input  wire logic      shift_i,   // Shift result out on serial_o
  input  wire logic      data_i,
  output dbg_word_t      crc_o,
  output logic           serial_o
);

  localparam dbg_word_t POLY = 32'hedb88320;  // Reflected polynomial

  dbg_word_t crc_q;
  dbg_word_t crc_step;

  // Next value for one input bit
  assign crc_step = {1'b0, crc_q[WORD_WIDTH-1:1]} ^ ((crc_q[0] ^ data_i) ? POLY : '0);

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= '1;
    end else if (clr_i) begin
      crc_q <= '1;
    end else if (en_i) begin
      crc_q <= crc_step;
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[WORD_WIDTH-1:1]};  // LSB goes out first
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];

endmodule

`default_nettype wire

/* dbg_or1k_pkg.sv */
// OR1K debug module package
// Opcodes, data register fields, widths, FSM states and the structs
// shared by the control path, datapath and SPR bus unit
`default_nettype none

package dbg_or1k_pkg;

  //////////////////////////////
  // Widths
  localparam int DR_WIDTH        = 53;  // TAP data register
  localparam int WORD_WIDTH      = 32;
  localparam int ADDR_WIDTH      = 32;
  localparam int COUNT_WIDTH     = 16;
  localparam int OP_WIDTH        = 4;
  localparam int REGSEL_WIDTH    = 1;
  localparam int BIT_COUNT_WIDTH = 6;   // Must reach WORD_WIDTH

  typedef logic [WORD_WIDTH-1:0]   dbg_word_t;
  typedef logic [ADDR_WIDTH-1:0]   dbg_addr_t;
  typedef logic [COUNT_WIDTH-1:0]  dbg_count_t;
  typedef logic [OP_WIDTH-1:0]     dbg_op_t;

  //////////////////////////////
  // Commands and fields
  localparam dbg_op_t CMD_BWRITE32 = 4'd3;
  localparam dbg_op_t CMD_BREAD32  = 4'd7;
  localparam dbg_op_t CMD_IREG_WR  = 4'd9;
  localparam dbg_op_t CMD_IREG_SEL = 4'd13;

  localparam logic [REGSEL_WIDTH-1:0] INTREG_STATUS = '0;

  localparam int CMD_FLAG_BIT = 52;      // Low for a module command
  localparam int OP_MSB       = 51;
  localparam int OP_LSB       = 48;
  localparam int ADDR_MSB     = 47;
  localparam int ADDR_LSB     = 16;
  localparam int COUNT_MSB    = 15;
  localparam int COUNT_LSB    = 0;
  localparam int REGSEL_BIT   = 47;
  localparam int STWR_MSB     = 46;      // Status write data
  localparam int STWR_LSB     = 45;

  typedef enum logic [3:0] {
    IDLE, RBEGIN, RREADY, RSTATUS, RBURST, RCRC,
    WREADY, WWAIT, WBURST, WCRC, WMATCH
  } dbg_state_e;

  typedef enum logic [1:0] {
    TDO_READY, TDO_DATA, TDO_MATCH, TDO_CRC
  } tdo_sel_e;

  // Datapath enables from the FSM
  typedef struct packed {
    logic     addr_ld;
    logic     addr_inc;
    logic     op_ld;
    logic     bit_clr;
    logic     bit_step;
    logic     word_ld;
    logic     word_dec;
    logic     out_ld;
    logic     out_shift;
    logic     out_intreg;  // Output reg loads internal register data
    logic     regsel_ld;
    logic     crc_clr;
    logic     crc_en;
    logic     crc_tdi;     // CRC fed from TDI, else from TDO data
    logic     crc_shift;
    tdo_sel_e tdo_sel;
  } dbg_ctrl_t;

  typedef struct packed {
    logic word_zero;
    logic word_last;  // Count is one
    logic bit_max;    // Bit 31 of a word
    logic bit_32;
  } dbg_stat_t;

  typedef struct packed {
    dbg_addr_t addr;
    dbg_word_t data;
    logic      stb;
    logic      we;
  } spr_req_t;

endpackage

`default_nettype wire
